// File: design/biquad_pkg.sv
// Biquad cascade shared definitions
// Widths, coefficient select and section FSM encodings, register map
`default_nettype none

package biquad_pkg;

    localparam int SAMPLE_W  = 16;    // Samples and Q2.14 coefficients
    localparam int ACC_W     = 32;    // Q4.28 products and their sum
    localparam int FRAC_BITS = 14;    // Shift back to Q2.14 at section output

    localparam int WB_ADR_W  = 6;
    localparam int SEC_SHIFT = 3;     // Eight words per section, five used
    localparam logic [WB_ADR_W-1:0] PEAK_ADDR = 6'd63;   // Read-only peak meter

    // Word offset inside a section, also the MAC operand select
    typedef enum logic [2:0] {
        COEF_B0 = 3'd0,
        COEF_B1 = 3'd1,
        COEF_B2 = 3'd2,
        COEF_A1 = 3'd3,
        COEF_A2 = 3'd4
    } coef_sel_e;

    // Values are consecutive, the section FSM steps through them in order
    typedef enum logic [3:0] {
        S_IDLE    = 4'd0,
        S_WAIT1   = 4'd1,
        S_WAIT2   = 4'd2,
        S_MULT_B0 = 4'd3,
        S_WAIT_B0 = 4'd4,
        S_MULT_B1 = 4'd5,
        S_WAIT_B1 = 4'd6,
        S_MULT_B2 = 4'd7,
        S_WAIT_B2 = 4'd8,
        S_MULT_A1 = 4'd9,
        S_WAIT_A1 = 4'd10,
        S_MULT_A2 = 4'd11,
        S_WAIT_A2 = 4'd12,
        S_DONE    = 4'd13
    } section_state_e;

endpackage

`default_nettype wire

// File: design/mac16_accum.sv
// Multiply-accumulate unit
// Registered 16x16 signed product, added or subtracted into a 32-bit
// accumulator on the cycle after the enable
`timescale 1ns/1ps
`default_nettype none

module mac16_accum (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  acc_clear,
    input  logic                                  ce,
    input  logic                                  sub,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] a_in,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] b_in,
    output logic signed [biquad_pkg::ACC_W-1:0]    result
);
    import biquad_pkg::*;

    logic signed [ACC_W-1:0] product;
    logic                    prod_valid;   // Product waiting to be summed
    logic                    prod_sub;

    // Multiplier stage
    always_ff @(posedge clk) begin
        if (!reset) begin
            product    <= '0;
            prod_valid <= 1'b0;
            prod_sub   <= 1'b0;
        end else if (acc_clear) begin
            product    <= '0;
            prod_valid <= 1'b0;
            prod_sub   <= 1'b0;
        end else begin
            prod_valid <= ce;
            if (ce) begin
                product  <= a_in * b_in;   // Q2.14 x Q2.14 -> Q4.28
                prod_sub <= sub;
            end
        end
    end

    // Accumulator stage
    always_ff @(posedge clk) begin
        if (!reset) begin
            result <= '0;
        end else if (acc_clear) begin
            result <= '0;
        end else if (prod_valid) begin
            if (prod_sub)
                result <= result - product;   // Feedback term
            else
                result <= result + product;
        end
    end

endmodule

`default_nettype wire

// File: design/biquad_section.sv
// Biquad IIR section, time-multiplexed over one MAC
// y[n] = b0 x[n] + b1 x[n-1] + b2 x[n-2] - a1 y[n-1] - a2 y[n-2]
// 14 cycles from start to done, output saturated to 16 bits
`timescale 1ns/1ps
`default_nettype none

module biquad_section (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] x_in,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] b0,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] b1,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] b2,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] a1,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] a2,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] y,
    output logic                                  done
);
    import biquad_pkg::*;

    localparam int SAT_MAX = (1 << (SAMPLE_W - 1)) - 1;
    localparam int SAT_MIN = -(1 << (SAMPLE_W - 1));

    section_state_e state;
    coef_sel_e      sel;

    logic signed [SAMPLE_W-1:0] x_n, x_n1, x_n2;
    logic signed [SAMPLE_W-1:0] y_n1, y_n2;
    logic signed [SAMPLE_W-1:0] mac_coef, mac_data;
    logic signed [SAMPLE_W-1:0] y_sat;
    logic signed [ACC_W-1:0]    mac_result;
    logic signed [ACC_W-1:0]    acc_shift;
    logic                       mac_ce, mac_sub, mac_clear;

    assign mac_clear = (state == S_IDLE) && start;

    // FSM walks the states in encoding order
    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE:  if (start) state <= S_WAIT1;
                S_DONE:  state <= S_IDLE;
                default: state <= section_state_e'(state + 4'd1);
            endcase
        end
    end

    // Input history shifts once per sample
    always_ff @(posedge clk) begin
        if (!reset) begin
            x_n  <= '0;
            x_n1 <= '0;
            x_n2 <= '0;
        end else if (mac_clear) begin
            x_n  <= x_in;
            x_n1 <= x_n;
            x_n2 <= x_n1;
        end
    end

    // MAC enable only in the MULT states
    always_comb begin
        mac_ce = 1'b1;
        sel    = COEF_B0;
        case (state)
            S_MULT_B0: sel = COEF_B0;
            S_MULT_B1: sel = COEF_B1;
            S_MULT_B2: sel = COEF_B2;
            S_MULT_A1: sel = COEF_A1;
            S_MULT_A2: sel = COEF_A2;
            default:   mac_ce = 1'b0;
        endcase
    end

    always_comb begin
        mac_sub  = 1'b0;
        mac_coef = b0;
        mac_data = x_n;
        case (sel)
            COEF_B1: begin
                mac_coef = b1;
                mac_data = x_n1;
            end
            COEF_B2: begin
                mac_coef = b2;
                mac_data = x_n2;
            end
            COEF_A1: begin
                mac_coef = a1;
                mac_data = y_n1;
                mac_sub  = 1'b1;   // Subtract, so a1 = -32768 stays exact
            end
            COEF_A2: begin
                mac_coef = a2;
                mac_data = y_n2;
                mac_sub  = 1'b1;
            end
            default: ;
        endcase
    end

    mac16_accum u_mac16_accum (
        .clk       (clk),
        .reset     (reset),
        .acc_clear (mac_clear),
        .ce        (mac_ce),
        .sub       (mac_sub),
        .a_in      (mac_coef),
        .b_in      (mac_data),
        .result    (mac_result)
    );

    // Back to Q2.14 and clamp to the sample range
    assign acc_shift = mac_result >>> FRAC_BITS;

    always_comb begin
        if (acc_shift > SAT_MAX)
            y_sat = {1'b0, {(SAMPLE_W-1){1'b1}}};
        else if (acc_shift < SAT_MIN)
            y_sat = {1'b1, {(SAMPLE_W-1){1'b0}}};
        else
            y_sat = acc_shift[SAMPLE_W-1:0];
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            y    <= '0;
            y_n1 <= '0;
            y_n2 <= '0;
            done <= 1'b0;
        end else begin
            done <= (state == S_DONE);
            if (state == S_DONE) begin
                y    <= y_sat;
                y_n1 <= y_sat;   // Feedback history
                y_n2 <= y_n1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/sample_framer.sv
// Sample framer
// Brings l_r_clk into the clk domain, detects either edge and
// captures the input sample with a one-cycle start pulse
`timescale 1ns/1ps
`default_nettype none

module sample_framer (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  l_r_clk,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] sample_in,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] frame_sample,
    output logic                                  frame_start
);

    logic lr_sync1, lr_sync2;   // Two-flop synchronizer
    logic lr_prev;              // Last synchronized level
    logic lr_edge;

    assign lr_edge = lr_sync2 ^ lr_prev;

    always_ff @(posedge clk) begin
        if (!reset) begin
            lr_sync1 <= 1'b0;
            lr_sync2 <= 1'b0;
            lr_prev  <= 1'b0;
        end else begin
            lr_sync1 <= l_r_clk;
            lr_sync2 <= lr_sync1;
            lr_prev  <= lr_sync2;
        end
    end

    // Edge register, sample taken on the same edge
    always_ff @(posedge clk) begin
        if (!reset) begin
            frame_start  <= 1'b0;
            frame_sample <= '0;
        end else begin
            frame_start <= lr_edge;
            if (lr_edge)
                frame_sample <= sample_in;
        end
    end

endmodule

`default_nettype wire

// File: design/coef_bank_wb.sv
// Coefficient register bank on a Wishbone classic slave
// Five Q2.14 coefficients per section, read back supported,
// peak meter at a fixed address with clear on read
`timescale 1ns/1ps
`default_nettype none

module coef_bank_wb #(
    parameter int NUM_SECTIONS = 2
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [biquad_pkg::WB_ADR_W-1:0]       wb_adr,
    input  logic [biquad_pkg::SAMPLE_W-1:0]       wb_dat_w,
    output logic [biquad_pkg::SAMPLE_W-1:0]       wb_dat_r,
    output logic                                  wb_ack,
    input  logic [biquad_pkg::SAMPLE_W-1:0]       peak_level,
    output logic                                  peak_clear,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] b0 [NUM_SECTIONS],
    output logic signed [biquad_pkg::SAMPLE_W-1:0] b1 [NUM_SECTIONS],
    output logic signed [biquad_pkg::SAMPLE_W-1:0] b2 [NUM_SECTIONS],
    output logic signed [biquad_pkg::SAMPLE_W-1:0] a1 [NUM_SECTIONS],
    output logic signed [biquad_pkg::SAMPLE_W-1:0] a2 [NUM_SECTIONS]
);
    import biquad_pkg::*;

    logic [WB_ADR_W-SEC_SHIFT-1:0] sec;
    coef_sel_e                     off;
    logic                          req;   // New access, ack goes out next edge
    logic [SAMPLE_W-1:0]           rd_mux;

    assign sec = wb_adr[WB_ADR_W-1:SEC_SHIFT];
    assign off = coef_sel_e'(wb_adr[SEC_SHIFT-1:0]);
    assign req = wb_cyc && wb_stb && !wb_ack;

    // Clears the meter on the edge that captures its value
    assign peak_clear = req && !wb_we && (wb_adr == PEAK_ADDR);

    always_comb begin
        rd_mux = '0;   // Unmapped words read zero
        if (wb_adr == PEAK_ADDR)
            rd_mux = peak_level;
        for (int s = 0; s < NUM_SECTIONS; s++) begin
            if (sec == s) begin
                case (off)
                    COEF_B0: rd_mux = b0[s];
                    COEF_B1: rd_mux = b1[s];
                    COEF_B2: rd_mux = b2[s];
                    COEF_A1: rd_mux = a1[s];
                    COEF_A2: rd_mux = a2[s];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
            for (int s = 0; s < NUM_SECTIONS; s++) begin
                b0[s] <= '0;
                b1[s] <= '0;
                b2[s] <= '0;
                a1[s] <= '0;
                a2[s] <= '0;
            end
        end else begin
            wb_ack <= req;
            if (req && !wb_we)
                wb_dat_r <= rd_mux;
            for (int s = 0; s < NUM_SECTIONS; s++) begin
                if (req && wb_we && sec == s) begin   // Live at once, no shadow copy
                    case (off)
                        COEF_B0: b0[s] <= wb_dat_w;
                        COEF_B1: b1[s] <= wb_dat_w;
                        COEF_B2: b2[s] <= wb_dat_w;
                        COEF_A1: a1[s] <= wb_dat_w;
                        COEF_A2: a2[s] <= wb_dat_w;
                        default: ;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/output_collector.sv
// Output collector
// Registers the last section's sample with a valid pulse and
// tracks the absolute peak until cleared
`timescale 1ns/1ps
`default_nettype none

module output_collector (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] y_in,
    input  logic                                  y_valid,
    input  logic                                  peak_clear,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] sample_out,
    output logic                                  out_valid,
    output logic [biquad_pkg::SAMPLE_W-1:0]       peak_level
);
    import biquad_pkg::*;

    logic [SAMPLE_W-1:0] abs_y;   // Unsigned, so |-32768| = 32768 fits

    assign abs_y = y_in[SAMPLE_W-1] ? (~y_in + 1'b1) : y_in;

    always_ff @(posedge clk) begin
        if (!reset) begin
            sample_out <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= y_valid;
            if (y_valid)
                sample_out <= y_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset)
            peak_level <= '0;
        else if (peak_clear)
            peak_level <= y_valid ? abs_y : '0;   // New sample starts the next window
        else if (y_valid && abs_y > peak_level)
            peak_level <= abs_y;
    end

endmodule

`default_nettype wire

// File: design/biquad_cascade_top.sv
// Mono biquad equalizer top
// Framer feeds a chain of identical biquad sections, the collector
// drains the last one, coefficients come from a Wishbone bank
`timescale 1ns/1ps
`default_nettype none

module biquad_cascade_top #(
    parameter int NUM_SECTIONS = 2   // 1 to 7
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  l_r_clk,
    input  logic signed [biquad_pkg::SAMPLE_W-1:0] sample_in,
    output logic signed [biquad_pkg::SAMPLE_W-1:0] sample_out,
    output logic                                  out_valid,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [biquad_pkg::WB_ADR_W-1:0]       wb_adr,
    input  logic [biquad_pkg::SAMPLE_W-1:0]       wb_dat_w,
    output logic [biquad_pkg::SAMPLE_W-1:0]       wb_dat_r,
    output logic                                  wb_ack
);
    import biquad_pkg::*;

    // Entry k feeds section k, the last entry feeds the collector
    logic signed [SAMPLE_W-1:0] y_chain    [NUM_SECTIONS+1];
    logic                       done_chain [NUM_SECTIONS+1];

    logic signed [SAMPLE_W-1:0] b0 [NUM_SECTIONS];
    logic signed [SAMPLE_W-1:0] b1 [NUM_SECTIONS];
    logic signed [SAMPLE_W-1:0] b2 [NUM_SECTIONS];
    logic signed [SAMPLE_W-1:0] a1 [NUM_SECTIONS];
    logic signed [SAMPLE_W-1:0] a2 [NUM_SECTIONS];

    logic [SAMPLE_W-1:0] peak_level;
    logic                peak_clear;

    sample_framer u_sample_framer (
        .clk          (clk),
        .reset        (reset),
        .l_r_clk      (l_r_clk),
        .sample_in    (sample_in),
        .frame_sample (y_chain[0]),
        .frame_start  (done_chain[0])
    );

    for (genvar k = 0; k < NUM_SECTIONS; k++) begin : g_section
        biquad_section u_biquad_section (
            .clk   (clk),
            .reset (reset),
            .start (done_chain[k]),
            .x_in  (y_chain[k]),
            .b0    (b0[k]),
            .b1    (b1[k]),
            .b2    (b2[k]),
            .a1    (a1[k]),
            .a2    (a2[k]),
            .y     (y_chain[k+1]),
            .done  (done_chain[k+1])
        );
    end

    output_collector u_output_collector (
        .clk        (clk),
        .reset      (reset),
        .y_in       (y_chain[NUM_SECTIONS]),
        .y_valid    (done_chain[NUM_SECTIONS]),
        .peak_clear (peak_clear),
        .sample_out (sample_out),
        .out_valid  (out_valid),
        .peak_level (peak_level)
    );

    coef_bank_wb #(
        .NUM_SECTIONS (NUM_SECTIONS)
    ) u_coef_bank_wb (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .peak_level (peak_level),
        .peak_clear (peak_clear),
        .b0         (b0),
        .b1         (b1),
        .b2         (b2),
        .a1         (a1),
        .a2         (a2)
    );

endmodule

`default_nettype wire

// File: dv/tb_biquad_cascade.sv
// Testbench for the biquad cascade equalizer
// Replays coefficient writes, input samples and expected outputs from a
// stimulus file, and checks Wishbone access, output timing and the peak meter
`timescale 1ns/1ps
`default_nettype none

module tb_biquad_cascade;
    import biquad_pkg::*;

    localparam int NUM_SECTIONS = 2;
    localparam int LATENCY      = 3 + 14 * NUM_SECTIONS + 1;   // l_r_clk edge to out_valid
    localparam int BASE_GAP     = LATENCY + 4;
    localparam int MAX_GAP      = BASE_GAP + 15;
    localparam int MAX_RECORDS  = 64;

    logic                       clk;
    logic                       reset;
    logic                       l_r_clk;
    logic signed [SAMPLE_W-1:0] sample_in;
    logic signed [SAMPLE_W-1:0] sample_out;
    logic                       out_valid;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [WB_ADR_W-1:0]        wb_adr;
    logic [SAMPLE_W-1:0]        wb_dat_w;
    logic [SAMPLE_W-1:0]        wb_dat_r;
    logic                       wb_ack;

    logic [35:0] records [0:MAX_RECORDS-1];   // Tag, field a, field b
    logic [31:0] lcg_state;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    biquad_cascade_top #(
        .NUM_SECTIONS (NUM_SECTIONS)
    ) u_biquad_cascade_top (
        .clk        (clk),
        .reset      (reset),
        .l_r_clk    (l_r_clk),
        .sample_in  (sample_in),
        .sample_out (sample_out),
        .out_valid  (out_valid),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [SAMPLE_W-1:0] actual,
                               input logic [SAMPLE_W-1:0] expected);
        if (actual !== expected)
            abort_run($sformatf("Fail at %0t: %s is %h, expected %h",
                                $time, name, actual, expected));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit)
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                cycle_limit));
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Classic cycle held until ack, then the ack must be gone one cycle later
    task automatic wb_cycle(input logic we, input logic [WB_ADR_W-1:0] adr,
                            input logic [SAMPLE_W-1:0] dat_w,
                            output logic [SAMPLE_W-1:0] dat_r);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat_w;
        do
            @(negedge clk);
        while (!wb_ack);
        dat_r  = wb_dat_r;   // Valid while ack is high
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        check_value("wb_ack", 16'(wb_ack), 16'h0000);
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [SAMPLE_W-1:0] dat);
        logic [SAMPLE_W-1:0] ignored;
        wb_cycle(1'b1, adr, dat, ignored);
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [SAMPLE_W-1:0] dat);
        wb_cycle(1'b0, adr, 16'h0000, dat);
    endtask

    // One l_r_clk toggle, then watch the whole sample period for the result
    task automatic play_sample(input logic [SAMPLE_W-1:0] x, input logic [SAMPLE_W-1:0] expected);
        int gap;
        int pulses;
        lcg_state = lcg_next(lcg_state);
        gap       = BASE_GAP + int'(lcg_state[19:16]);   // 0 to 15 extra idle cycles
        pulses    = 0;
        @(negedge clk);
        sample_in = x;
        l_r_clk   = ~l_r_clk;
        for (int i = 1; i <= gap; i++) begin
            @(negedge clk);
            if (out_valid) begin
                pulses++;
                check_value("out_valid latency", 16'(i), 16'(LATENCY));
                check_value("sample_out", sample_out, expected);
            end
        end
        check_value("out_valid pulse count", 16'(pulses), 16'd1);
    endtask

    initial begin
        logic [SAMPLE_W-1:0] rd;
        logic [3:0]          tag;
        logic [15:0]         field_a;
        logic [15:0]         field_b;
        int                  n_records;

        reset     = 1'b0;
        l_r_clk   = 1'b0;
        sample_in = '0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        lcg_state = 32'he341;

        $readmemh("dv/biquad_stimulus.hex", records);
        n_records = 0;
        while (n_records < MAX_RECORDS && records[n_records][35:32] != 4'h0)
            n_records++;
        if (n_records == 0)
            abort_run("Stimulus file is missing or holds no records");
        cycle_limit = 200 + n_records * MAX_GAP;

        repeat (5) @(negedge clk);
        reset = 1'b1;

        repeat (10) begin   // No output without input
            @(negedge clk);
            check_value("out_valid", 16'(out_valid), 16'h0000);
        end
        for (int s = 0; s < NUM_SECTIONS; s++) begin
            for (int c = 0; c < 5; c++) begin
                wb_read(6'(s * 8 + c), rd);
                check_value("wb_dat_r", rd, 16'h0000);
            end
        end

        // Word 5 is a hole inside section 0, word 40 belongs to an absent section
        wb_write(6'd5, 16'ha5a5);
        wb_read(6'd5, rd);
        check_value("wb_dat_r", rd, 16'h0000);
        wb_write(6'd40, 16'h5a5a);
        wb_read(6'd40, rd);
        check_value("wb_dat_r", rd, 16'h0000);

        for (int r = 0; r < n_records; r++) begin
            tag     = records[r][35:32];
            field_a = records[r][31:16];
            field_b = records[r][15:0];
            case (tag)
                4'h1: begin
                    wb_write(field_a[WB_ADR_W-1:0], field_b);
                    wb_read(field_a[WB_ADR_W-1:0], rd);
                    check_value("wb_dat_r", rd, field_b);
                end
                4'h2: play_sample(field_a, field_b);
                4'h3: begin
                    wb_read(PEAK_ADDR, rd);
                    check_value("peak_level", rd, field_b);
                    wb_read(PEAK_ADDR, rd);   // Cleared by the first read
                    check_value("peak_level", rd, 16'h0000);
                end
                default: abort_run($sformatf("Unknown record tag %h in record %0d", tag, r));
            endcase
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/biquad_stimulus.hex
// Each record is tag, field a, field b: 1 = write (word address, value),
// 2 = sample (input, expected output), 3 = peak read (unused, expected), 0 = end
// Pass-through, b0 = 1.0 in both sections
100004000
100084000
212341234
2FFFFFFFF
27FFF7FFF
280008000
200000000
300008000
// Saturation, b0 = 2.0 in both sections, zeros flush the histories
100007FFF
100087FFF
240007FFF
27FFF7FFF
280008000
2C0008000
2FF00FC00
200000000
200000000
200000000
300008000
// Low-pass in section 0, peaking in section 1
100001000
100012000
100021000
10003E000
100040800
100085000
10009C000
1000A2000
1000BC000
1000C1000
2032000FA
20320039D
203200684
2F9C005E1
2000001D6
20000FFE8
300000684
000000000

// File: flist.f
design/biquad_pkg.sv
design/mac16_accum.sv
design/biquad_section.sv
design/sample_framer.sv
design/coef_bank_wb.sv
design/output_collector.sv
design/biquad_cascade_top.sv
dv/tb_biquad_cascade.sv

// File: Makefile
# Verilator build and run of the biquad cascade testbench

VERILATOR ?= verilator
TOP       ?= tb_biquad_cascade
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
